// File: hdl/bridge_defines.svh
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// Payload width in bits.
`define BRIDGE_DATA_W 16

// FIFO depth, a power of two.
`define BRIDGE_DEPTH 16

// Flag thresholds, in entries.
`define BRIDGE_AFULL 14
`define BRIDGE_AEMPTY 2

// Register map for both ports.
`define BRIDGE_ADDR_DATA 1'b0
`define BRIDGE_ADDR_STAT 1'b1

`endif

// File: hdl/wb_pkg.sv
`default_nettype none

`include "bridge_defines.svh"

package wb_pkg;

  // Master to slave, held steady until ack or err.
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic                      adr;  // One register bit.
    logic [`BRIDGE_DATA_W-1:0] dat;
  } wb_req_t;

  // Slave to master.
  typedef struct packed {
    logic                      ack;
    logic                      err;
    logic [`BRIDGE_DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/fifo_pkg.sv
`default_nettype none

`include "bridge_defines.svh"

package fifo_pkg;

  // Level counts 0 to depth, so one bit above the address.
  localparam int unsigned lvl_w = $clog2(`BRIDGE_DEPTH) + 1;

  typedef logic [`BRIDGE_DATA_W-1:0] fifo_entry_t;

  typedef struct packed {
    logic             full;
    logic             empty;
    logic             afull;
    logic             aempty;
    logic [lvl_w-1:0] level;
  } fifo_status_t;

  typedef struct packed {
    logic        push;
    fifo_entry_t entry;
  } push_req_t;

  typedef struct packed {
    logic pop;
  } pop_req_t;

endpackage

`default_nettype wire

// File: hdl/fifo_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module fifo_ram #(
  parameter int unsigned depth = `BRIDGE_DEPTH
) (
  input  wire logic                     wr_clk,
  input  wire logic                     wr_en,
  input  wire logic [$clog2(depth)-1:0] wr_addr,
  input  wire fifo_pkg::fifo_entry_t    wr_data,
  input  wire logic                     rd_clk,
  input  wire logic                     rd_rst_n,
  input  wire logic                     rd_en,
  input  wire logic [$clog2(depth)-1:0] rd_addr,
  output fifo_pkg::fifo_entry_t         rd_data
);
  import fifo_pkg::*;

  fifo_entry_t mem [depth];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, holds its word between pops.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/async_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module async_fifo #(
  parameter int unsigned depth      = `BRIDGE_DEPTH,
  parameter int unsigned afull_thr  = `BRIDGE_AFULL,
  parameter int unsigned aempty_thr = `BRIDGE_AEMPTY
) (
  input  wire logic                   wr_clk,
  input  wire logic                   wr_rst_n,
  input  wire fifo_pkg::push_req_t    push,
  output fifo_pkg::fifo_status_t      wr_status,
  input  wire logic                   rd_clk,
  input  wire logic                   rd_rst_n,
  input  wire fifo_pkg::pop_req_t     pop,
  output fifo_pkg::fifo_entry_t       rd_data,
  output fifo_pkg::fifo_status_t      rd_status
);
  import fifo_pkg::*;

  localparam int unsigned addr_w = $clog2(depth);
  localparam int unsigned ptr_w  = addr_w + 1;

  // Write domain.
  logic [ptr_w-1:0] wr_bin;
  logic [ptr_w-1:0] wr_bin_nxt;
  logic [ptr_w-1:0] wr_gray;
  logic [ptr_w-1:0] rd_gray_w1;
  logic [ptr_w-1:0] rd_gray_w2;
  logic [ptr_w-1:0] wr_lvl_nxt;

  // Read domain.
  logic [ptr_w-1:0] rd_bin;
  logic [ptr_w-1:0] rd_bin_nxt;
  logic [ptr_w-1:0] rd_gray;
  logic [ptr_w-1:0] wr_gray_r1;
  logic [ptr_w-1:0] wr_gray_r2;
  logic [ptr_w-1:0] rd_lvl_nxt;

  function automatic logic [ptr_w-1:0] bin2gray(input logic [ptr_w-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [ptr_w-1:0] gray2bin(input logic [ptr_w-1:0] g);
    logic [ptr_w-1:0] b;
    b[ptr_w-1] = g[ptr_w-1];
    for (int i = ptr_w - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  function automatic fifo_status_t make_status(input logic [ptr_w-1:0] lvl);
    fifo_status_t s;
    s.full   = (lvl == ptr_w'(depth));
    s.empty  = (lvl == '0);
    s.afull  = (lvl >= ptr_w'(afull_thr));
    s.aempty = (lvl <= ptr_w'(aempty_thr));
    s.level  = lvl_w'(lvl);
    return s;
  endfunction

  // Push strobe is trusted, the port checks full.
  assign wr_bin_nxt = wr_bin + ptr_w'(push.push);
  assign wr_lvl_nxt = wr_bin_nxt - gray2bin(rd_gray_w2);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
      wr_status  <= make_status('0);
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= bin2gray(wr_bin_nxt);
      rd_gray_w1 <= rd_gray;  // Crosses from rd_clk.
      rd_gray_w2 <= rd_gray_w1;
      wr_status  <= make_status(wr_lvl_nxt);
    end
  end

  assign rd_bin_nxt = rd_bin + ptr_w'(pop.pop);
  assign rd_lvl_nxt = gray2bin(wr_gray_r2) - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
      rd_status  <= make_status('0);
    end else begin
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= bin2gray(rd_bin_nxt);
      wr_gray_r1 <= wr_gray;  // Crosses from wr_clk.
      wr_gray_r2 <= wr_gray_r1;
      rd_status  <= make_status(rd_lvl_nxt);
    end
  end

  fifo_ram #(
    .depth (depth)
  ) u_ram (
    .wr_clk   (wr_clk),
    .wr_en    (push.push),
    .wr_addr  (wr_bin[addr_w-1:0]),
    .wr_data  (push.entry),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (pop.pop),
    .rd_addr  (rd_bin[addr_w-1:0]),
    .rd_data  (rd_data)
  );

  a_no_push_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    push.push |-> !wr_status.full)
    else $error("push while full");

  a_no_pop_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    pop.pop |-> !rd_status.empty)
    else $error("pop while empty");

  a_wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1)
    else $error("write Gray pointer moved more than one bit");

  a_rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1)
    else $error("read Gray pointer moved more than one bit");

endmodule

`default_nettype wire

// File: hdl/wb_push_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module wb_push_port (
  input  wire logic                   wr_clk,
  input  wire logic                   wr_rst_n,
  input  wire wb_pkg::wb_req_t        bus,
  output wb_pkg::wb_rsp_t             rsp,
  output fifo_pkg::push_req_t         push,
  input  wire fifo_pkg::fifo_status_t status
);
  import fifo_pkg::*;

  localparam int unsigned dw = $bits(fifo_entry_t);

  logic        start;
  logic        is_data;
  logic        ack_q;
  logic        err_q;
  fifo_entry_t dat_q;

  // No new start while the answer is on the bus.
  assign start   = bus.cyc && bus.stb && !ack_q && !err_q;
  assign is_data = (bus.adr == `BRIDGE_ADDR_DATA);

  // RAM write lands on the same edge as the ack.
  assign push.push  = start && bus.we && is_data && !status.full;
  assign push.entry = bus.dat;

  assign rsp.ack = ack_q;
  assign rsp.err = err_q;
  assign rsp.dat = dat_q;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      if (start) begin
        if (bus.we) begin
          ack_q <= is_data && !status.full;
          err_q <= !is_data || status.full;  // Status is read only.
        end else begin
          ack_q <= !is_data;
          err_q <= is_data;  // No data to read here.
        end
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (start) begin
      dat_q <= dw'(status);
    end
  end

  a_one_answer: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    (ack_q || err_q) |-> !(ack_q && err_q) ##1 !(ack_q || err_q))
    else $error("push port answer overlaps or lasts too long");

endmodule

`default_nettype wire

// File: hdl/wb_pop_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module wb_pop_port (
  input  wire logic                   rd_clk,
  input  wire logic                   rd_rst_n,
  input  wire wb_pkg::wb_req_t        bus,
  output wb_pkg::wb_rsp_t             rsp,
  output fifo_pkg::pop_req_t          pop,
  input  wire fifo_pkg::fifo_status_t status,
  input  wire fifo_pkg::fifo_entry_t  rd_data
);
  import fifo_pkg::*;

  localparam int unsigned dw = $bits(fifo_entry_t);

  typedef enum logic [1:0] {
    st_idle,
    st_read,    // Pop strobe at the RAM.
    st_answer
  } state_t;

  state_t      state;
  logic        start;
  logic        is_data;
  logic        ack_q;
  logic        err_q;
  logic        data_sel;
  fifo_entry_t stat_q;

  assign start   = bus.cyc && bus.stb && (state == st_idle);
  assign is_data = (bus.adr == `BRIDGE_ADDR_DATA);

  assign pop.pop = (state == st_read);

  // Read data comes straight from the RAM register.
  assign rsp.ack = ack_q;
  assign rsp.err = err_q;
  assign rsp.dat = data_sel ? rd_data : stat_q;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state    <= st_idle;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      data_sel <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            data_sel <= !bus.we && is_data;
            if (!bus.we && is_data && !status.empty) begin
              state <= st_read;
            end else begin
              state <= st_answer;
              ack_q <= !bus.we && !is_data;
              err_q <= bus.we || is_data;  // Write, or read when empty.
            end
          end
        end
        st_read: begin
          state <= st_answer;
          ack_q <= 1'b1;
        end
        st_answer: begin
          state <= st_idle;
          ack_q <= 1'b0;
          err_q <= 1'b0;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge rd_clk) begin
    if (start) begin
      stat_q <= dw'(status);
    end
  end

  // A pop only serves the data read the master still holds.
  a_pop_held_read: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    pop.pop |-> bus.cyc && bus.stb && !bus.we && (bus.adr == `BRIDGE_ADDR_DATA))
    else $error("pop issued without a pending data read");

endmodule

`default_nettype wire

// File: hdl/fifo_bridge_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module fifo_bridge_top (
  input  wire logic            wr_clk,
  input  wire logic            wr_rst_n,
  input  wire wb_pkg::wb_req_t wr_bus,
  output wb_pkg::wb_rsp_t      wr_rsp,
  input  wire logic            rd_clk,
  input  wire logic            rd_rst_n,
  input  wire wb_pkg::wb_req_t rd_bus,
  output wb_pkg::wb_rsp_t      rd_rsp
);
  import fifo_pkg::*;

  push_req_t    push;
  pop_req_t     pop;
  fifo_status_t wr_status;
  fifo_status_t rd_status;
  fifo_entry_t  rd_data;

  wb_push_port u_push (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .bus      (wr_bus),
    .rsp      (wr_rsp),
    .push     (push),
    .status   (wr_status)
  );

  async_fifo #(
    .depth      (`BRIDGE_DEPTH),
    .afull_thr  (`BRIDGE_AFULL),
    .aempty_thr (`BRIDGE_AEMPTY)
  ) u_fifo (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .push      (push),
    .wr_status (wr_status),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .pop       (pop),
    .rd_data   (rd_data),
    .rd_status (rd_status)
  );

  wb_pop_port u_pop (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .bus      (rd_bus),
    .rsp      (rd_rsp),
    .pop      (pop),
    .status   (rd_status),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

// File: verif/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module tb_checker (
  input wire logic            wr_clk,
  input wire logic            wr_rst_n,
  input wire wb_pkg::wb_req_t wr_bus,
  input wire wb_pkg::wb_rsp_t wr_rsp,
  input wire logic            rd_clk,
  input wire logic            rd_rst_n,
  input wire wb_pkg::wb_req_t rd_bus,
  input wire wb_pkg::wb_rsp_t rd_rsp,
  input wire logic            rd_empty
);
  import fifo_pkg::*;

  fifo_entry_t model[$];  // Reference model of the FIFO contents.
  string       test_name = "none";
  int          test_checks;
  int          test_errors;
  int          tests;
  int          checks;
  int          errors;
  logic        empty_d;    // Read-side empty as the pop port saw it.
  logic [16:0] expected;

  // Next pop word with a valid bit, or a predicted err when nothing is queued.
  function automatic logic [16:0] expect_pop();
    if (model.size() == 0) begin
      return '0;
    end
    return {1'b1, model[0]};
  endfunction

  function automatic int model_size();
    return model.size();
  endfunction

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
    test_checks++;
    if (exp !== act) begin
      test_errors++;
      $display("ERROR %s/%s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    test_checks++;
    test_errors++;
    $display("Test %s failed: %s", test_name, msg);
  endtask

  task automatic report_test();
    tests++;
    checks += test_checks;
    errors += test_errors;
    $display("Test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic report_totals();
    $display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
  endtask

  // Only acked data writes enter the model.
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_rsp.ack && wr_bus.we && wr_bus.adr == `BRIDGE_ADDR_DATA) begin
      model.push_back(wr_bus.dat);
    end
  end

  always @(posedge rd_clk) begin
    if (rd_rst_n && !rd_bus.we && rd_bus.adr == `BRIDGE_ADDR_DATA) begin
      if (rd_rsp.ack) begin
        expected = expect_pop();
        if (!expected[16]) begin
          note_failure("a pop was acked while the model queue was empty");
        end else begin
          compare("pop data", expected[15:0], rd_rsp.dat);
          model.delete(0);
        end
      end
      if (rd_rsp.err && !empty_d) begin
        note_failure("a pop answered err while the read side was not empty");
      end
    end
    empty_d <= rd_empty;
  end

endmodule

`default_nettype wire

// File: verif/tb_fifo_bridge.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module tb_fifo_bridge;
  import wb_pkg::*;
  import fifo_pkg::*;

  localparam int timeout = 50;

  logic        wr_clk = 1'b0;
  logic        rd_clk = 1'b0;
  logic        wr_rst_n = 1'b0;
  logic        rd_rst_n = 1'b0;
  wb_req_t     wr_bus = '0;
  wb_req_t     rd_bus = '0;
  wb_rsp_t     wr_rsp;
  wb_rsp_t     rd_rsp;
  wire logic   rd_empty = uut.u_fifo.rd_status.empty;
  int          seed = 32'hb8a5e01a;
  logic        ack;
  logic        err;
  logic [15:0] rdat;
  int          lat;
  int          n;

  always #5 wr_clk = ~wr_clk;
  always #7 rd_clk = ~rd_clk;

  fifo_bridge_top uut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_bus   (wr_bus),
    .wr_rsp   (wr_rsp),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_bus   (rd_bus),
    .rd_rsp   (rd_rsp)
  );

  tb_checker chk (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_bus   (wr_bus),
    .wr_rsp   (wr_rsp),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_bus   (rd_bus),
    .rd_rsp   (rd_rsp),
    .rd_empty (rd_empty)
  );

  // Status register value for a FIFO holding n words.
  function automatic logic [15:0] expected_status(input int n);
    fifo_status_t s;
    s.full   = (n == `BRIDGE_DEPTH);
    s.empty  = (n == 0);
    s.afull  = (n >= `BRIDGE_AFULL);
    s.aempty = (n <= `BRIDGE_AEMPTY);
    s.level  = lvl_w'(n);
    return 16'(s);
  endfunction

  task automatic abort_run(input string msg);
    $display("Timeout: %s", msg);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic wr_access(input logic we, input logic adr, input logic [15:0] dat,
                           output logic a, output logic e, output logic [15:0] d);
    int k;
    @(posedge wr_clk);
    wr_bus <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    k = 0;
    do begin
      @(posedge wr_clk);
      k++;
    end while (!(wr_rsp.ack || wr_rsp.err) && k < timeout);
    a = wr_rsp.ack;
    e = wr_rsp.err;
    d = wr_rsp.dat;
    wr_bus <= '0;
    if (!(a || e)) abort_run("no ack or err on the write bus");
  endtask

  // Latency counts from the first edge that sees the strobe.
  task automatic rd_access(input logic we, input logic adr, output logic a, output logic e,
                           output logic [15:0] d, output int l);
    int k;
    @(posedge rd_clk);
    rd_bus <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: 16'h5a5a};
    k = 0;
    do begin
      @(posedge rd_clk);
      k++;
    end while (!(rd_rsp.ack || rd_rsp.err) && k < timeout);
    a = rd_rsp.ack;
    e = rd_rsp.err;
    d = rd_rsp.dat;
    l = k - 1;
    rd_bus <= '0;
    if (!(a || e)) abort_run("no ack or err on the read bus");
  endtask

  task automatic push_word(input logic [15:0] w);
    wr_access(1'b1, `BRIDGE_ADDR_DATA, w, ack, err, rdat);
  endtask

  task automatic pop_word();
    rd_access(1'b0, `BRIDGE_ADDR_DATA, ack, err, rdat, lat);
  endtask

  // Both levels match the model once the pointers have crossed.
  task automatic wait_settled();
    logic [15:0] ws;
    logic [15:0] rs;
    int k;
    k = 0;
    do begin
      wr_access(1'b0, `BRIDGE_ADDR_STAT, 16'h0, ack, err, ws);
      rd_access(1'b0, `BRIDGE_ADDR_STAT, ack, err, rs, lat);
      k++;
    end while ((ws[4:0] != 5'(chk.model_size()) || rs[4:0] != 5'(chk.model_size()))
               && k < timeout);
    if (k >= timeout) abort_run("FIFO levels did not settle");
  endtask

  task automatic check_status(input string name);
    wait_settled();
    wr_access(1'b0, `BRIDGE_ADDR_STAT, 16'h0, ack, err, rdat);
    chk.compare({name, " wr status ack"}, 16'd1, {15'd0, ack});
    chk.compare({name, " wr status"}, expected_status(chk.model_size()), rdat);
    rd_access(1'b0, `BRIDGE_ADDR_STAT, ack, err, rdat, lat);
    chk.compare({name, " rd status ack"}, 16'd1, {15'd0, ack});
    chk.compare({name, " rd status"}, expected_status(chk.model_size()), rdat);
  endtask

  task automatic drain();
    int k;
    k = 0;
    while (chk.model_size() > 0 && k < 4 * timeout) begin
      pop_word();
      k++;
    end
    if (chk.model_size() > 0) chk.note_failure("the drain left words in the model queue");
    check_status("drained");
  endtask

  initial begin
    fork
      begin
        repeat (8) @(posedge wr_clk);
        wr_rst_n <= 1'b1;
      end
      begin
        repeat (8) @(posedge rd_clk);
        rd_rst_n <= 1'b1;
      end
    join

    chk.begin_test("reset");
    check_status("reset");
    pop_word();
    chk.compare("empty pop err", 16'd1, {15'd0, err});
    chk.report_test();

    chk.begin_test("order");
    repeat (10) push_word(16'($random(seed)));
    wait_settled();
    repeat (10) begin
      pop_word();
      chk.compare("pop latency", 16'd2, 16'(lat));
    end
    chk.report_test();

    chk.begin_test("overflow");
    repeat (`BRIDGE_DEPTH) push_word(16'($random(seed)));
    n = 0;
    do begin
      wr_access(1'b0, `BRIDGE_ADDR_STAT, 16'h0, ack, err, rdat);
      n++;
    end while (!rdat[8] && n < timeout);
    if (!rdat[8]) abort_run("write side never reported full");
    push_word(16'hdead);
    chk.compare("push when full err", 16'd1, {15'd0, err});
    drain();
    chk.report_test();

    chk.begin_test("thresholds");
    for (int i = 1; i <= 15; i++) begin
      push_word(16'($random(seed)));
      if (i == 2 || i == 3 || i == 13 || i == 14) check_status("level");
    end
    drain();
    chk.report_test();

    chk.begin_test("concurrent");
    fork
      repeat (150) begin
        repeat ($random(seed) & 3) @(posedge wr_clk);
        push_word(16'($random(seed)));
      end
      repeat (150) begin
        repeat ($random(seed) & 3) @(posedge rd_clk);
        pop_word();
      end
    join
    drain();
    pop_word();
    chk.compare("pop after drain err", 16'd1, {15'd0, err});
    chk.report_test();

    chk.begin_test("illegal");
    push_word(16'h1234);
    push_word(16'h5678);
    rd_access(1'b1, `BRIDGE_ADDR_DATA, ack, err, rdat, lat);
    chk.compare("pop port write err", 16'd1, {15'd0, err});
    wr_access(1'b1, `BRIDGE_ADDR_STAT, 16'hffff, ack, err, rdat);
    chk.compare("status write err", 16'd1, {15'd0, err});
    check_status("after illegal");
    drain();
    chk.report_test();

    chk.report_totals();
    if (chk.errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fifo_bridge.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/fifo_pkg.sv
hdl/fifo_ram.sv
hdl/async_fifo.sv
hdl/wb_push_port.sv
hdl/wb_pop_port.sv
hdl/fifo_bridge_top.sv
verif/tb_checker.sv
verif/tb_fifo_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator; exits nonzero on failure.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f fifo_bridge.f \
  --top-module tb_fifo_bridge -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
